// File: verilog/collatz_pkg.sv
// collatz explorer shared definitions
// arithmetic width, tiny raster geometry, font cell sizes and colours
package collatz_pkg;

  // search arithmetic
  localparam int collatz_bits = 32;
  localparam logic [collatz_bits-1:0] start_init = collatz_bits'(3);

  // raster size in pixels, blanking follows the visible area
  localparam int h_visible = 64;
  localparam int h_total   = 80;
  localparam int v_visible = 16;
  localparam int v_total   = 20;

  // sync pulses sit inside the blanking intervals, active high
  localparam int h_sync_start = 68;
  localparam int h_sync_end   = 76;
  localparam int v_sync_start = 17;
  localparam int v_sync_end   = 19;

  localparam int beam_x_bits = 7;
  localparam int beam_y_bits = 5;

  // 3x5 glyphs inside a 4x6 character cell
  localparam int glyph_w    = 3;
  localparam int glyph_h    = 5;
  localparam int cell_w     = 4;
  localparam int cell_h     = 6;
  localparam int hex_digits = 8;

  // 16 stable cycles accept a new button level
  localparam int debounce_bits = 4;

  // RGB565 pixels
  localparam int color_bits = 16;
  localparam logic [color_bits-1:0] color_fg = {color_bits{1'b1}};
  localparam logic [color_bits-1:0] color_bg = '0;

endpackage

// File: verilog/video_beam_if.sv
// video beam bundle
// beam position with sync and blank, from the raster counters to the renderer
`timescale 1ns/100ps

interface video_beam_if import collatz_pkg::*; ();

  logic [beam_x_bits-1:0] beam_x;
  logic [beam_y_bits-1:0] beam_y;
  logic                   hsync;
  logic                   vsync;
  logic                   blank;

  // raster counters
  modport source (output beam_x, beam_y, hsync, vsync, blank);

  // pixel generation
  modport sink (input beam_x, beam_y, hsync, vsync, blank);

endinterface

// File: verilog/step_control.sv
// step control
// debounces the step button and merges its rising edge with the run switch
`timescale 1ns/100ps

module step_control import collatz_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic btn_step,
  input  logic run,
  output logic step
);

  logic                     btn_sync_1;
  logic                     btn_sync_2;
  logic [debounce_bits-1:0] stable_cnt;
  logic                     btn_level;
  logic                     btn_level_prev;
  logic                     btn_rise_q;
  logic                     run_q;

  // two flops against metastability
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      btn_sync_1 <= 1'b0;
      btn_sync_2 <= 1'b0;
    end
    else
    begin
      btn_sync_1 <= btn_step;
      btn_sync_2 <= btn_sync_1;
    end
  end

  // count cycles the input differs from the accepted level
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stable_cnt <= '0;
      btn_level  <= 1'b0;
    end
    else if (btn_sync_2 == btn_level)
    begin
      stable_cnt <= '0;
    end
    else if (stable_cnt == {debounce_bits{1'b1}})
    begin
      // held long enough, take the new level
      btn_level  <= btn_sync_2;
      stable_cnt <= '0;
    end
    else
    begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  // registered rising edge and run switch
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      btn_level_prev <= 1'b0;
      btn_rise_q     <= 1'b0;
      run_q          <= 1'b0;
    end
    else
    begin
      btn_level_prev <= btn_level;
      btn_rise_q     <= btn_level & ~btn_level_prev;
      run_q          <= run;
    end
  end

  assign step = btn_rise_q | run_q;

endmodule

// File: verilog/collatz_explorer.sv
// collatz search engine
// iterates the working value until it drops below the start number, then moves on
`timescale 1ns/100ps

module collatz_explorer import collatz_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    step,
  output logic [collatz_bits-1:0] start_num,
  output logic [collatz_bits-1:0] actual
);

  logic [collatz_bits-1:0] next_start;
  logic [collatz_bits-1:0] odd_next;
  logic [collatz_bits-1:0] even_next;
  logic                    proven;

  assign next_start = start_num + 1'b1;

  // 3n+1 as 2n+n+1, wraps at the word width
  assign odd_next  = {actual[collatz_bits-2:0], 1'b0} + actual + 1'b1;
  assign even_next = {1'b0, actual[collatz_bits-1:1]};

  // every smaller start was already shown to reach 1
  assign proven = actual < start_num;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      start_num <= start_init;
      actual    <= start_init;
    end
    else if (step)
    begin
      if (proven)
      begin
        start_num <= next_start;
        actual    <= next_start;
      end
      else if (actual[0])
      begin
        actual <= odd_next;
      end
      else
      begin
        actual <= even_next;
      end
    end
  end

endmodule

// File: verilog/video_timing.sv
// video timing
// horizontal and vertical raster counters with sync and blank decode
`timescale 1ns/100ps

module video_timing import collatz_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  video_beam_if.source beam
);

  logic [beam_x_bits-1:0] x_cnt;
  logic [beam_y_bits-1:0] y_cnt;
  logic                   x_wrap;
  logic                   y_wrap;

  assign x_wrap = x_cnt == beam_x_bits'(h_total - 1);
  assign y_wrap = y_cnt == beam_y_bits'(v_total - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      x_cnt <= '0;
      y_cnt <= '0;
    end
    else
    begin
      if (x_wrap)
      begin
        x_cnt <= '0;
        // next line, or back to the top
        if (y_wrap)
          y_cnt <= '0;
        else
          y_cnt <= y_cnt + 1'b1;
      end
      else
      begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  assign beam.beam_x = x_cnt;
  assign beam.beam_y = y_cnt;

  // syncs and blank follow the counters in the same cycle
  assign beam.hsync = (x_cnt >= beam_x_bits'(h_sync_start)) &&
                      (x_cnt <  beam_x_bits'(h_sync_end));
  assign beam.vsync = (y_cnt >= beam_y_bits'(v_sync_start)) &&
                      (y_cnt <  beam_y_bits'(v_sync_end));
  assign beam.blank = (x_cnt >= beam_x_bits'(h_visible)) ||
                      (y_cnt >= beam_y_bits'(v_visible));

endmodule

// File: verilog/hex_text_renderer.sv
// hex text renderer
// snapshots the search state each frame and draws it as two rows of hex digits
`timescale 1ns/100ps

module hex_text_renderer import collatz_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  video_beam_if.sink              beam,
  input  logic [collatz_bits-1:0] start_num,
  input  logic [collatz_bits-1:0] actual,
  output logic [color_bits-1:0]   color,
  output logic                    hsync_out,
  output logic                    vsync_out,
  output logic                    blank_out
);

  logic [collatz_bits-1:0] start_snap;
  logic [collatz_bits-1:0] actual_snap;
  logic                    vsync_prev;
  logic [beam_x_bits-1:0]  col;
  logic [beam_x_bits-1:0]  px;
  logic [beam_y_bits-1:0]  row;
  logic [beam_y_bits-1:0]  py;
  logic [collatz_bits-1:0] row_val;
  logic [2:0]              digit_idx;
  logic [3:0]              nibble;
  logic [14:0]             glyph;
  logic [3:0]              bit_sel;
  logic                    in_glyph;
  logic                    in_text;
  logic                    pixel_on;

  // bit 14 is the top left pixel, each row of three reads left to right
  function automatic logic [14:0] hex_glyph(input logic [3:0] digit);
    case (digit)
      4'h0:    hex_glyph = 15'b111_101_101_101_111;
      4'h1:    hex_glyph = 15'b010_110_010_010_111;
      4'h2:    hex_glyph = 15'b111_001_111_100_111;
      4'h3:    hex_glyph = 15'b111_001_111_001_111;
      4'h4:    hex_glyph = 15'b101_101_111_001_001;
      4'h5:    hex_glyph = 15'b111_100_111_001_111;
      4'h6:    hex_glyph = 15'b111_100_111_101_111;
      4'h7:    hex_glyph = 15'b111_001_001_001_001;
      4'h8:    hex_glyph = 15'b111_101_111_101_111;
      4'h9:    hex_glyph = 15'b111_101_111_001_111;
      4'ha:    hex_glyph = 15'b010_101_111_101_101;
      4'hb:    hex_glyph = 15'b110_101_110_101_110;
      4'hc:    hex_glyph = 15'b011_100_100_100_011;
      4'hd:    hex_glyph = 15'b110_101_101_101_110;
      4'he:    hex_glyph = 15'b111_100_111_100_111;
      default: hex_glyph = 15'b111_100_111_100_100;
    endcase
  endfunction

  // frame snapshot on vsync rise, stable for the whole visible area
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vsync_prev  <= 1'b0;
      start_snap  <= '0;
      actual_snap <= '0;
    end
    else
    begin
      vsync_prev <= beam.vsync;
      if (beam.vsync && !vsync_prev)
      begin
        start_snap  <= start_num;
        actual_snap <= actual;
      end
    end
  end

  // character cell and pixel inside it
  assign col = beam_x_bits'(beam.beam_x / cell_w);
  assign px  = beam_x_bits'(beam.beam_x % cell_w);
  assign row = beam_y_bits'(beam.beam_y / cell_h);
  assign py  = beam_y_bits'(beam.beam_y % cell_h);

  // row 0 start number, row 1 working value, column 0 is the top nibble
  assign row_val   = (row == '0) ? start_snap : actual_snap;
  assign digit_idx = 3'(hex_digits - 1) - col[2:0];
  assign nibble    = row_val[{digit_idx, 2'b00} +: 4];
  assign glyph     = hex_glyph(nibble);

  assign in_glyph = (px < beam_x_bits'(glyph_w)) && (py < beam_y_bits'(glyph_h));
  assign in_text  = (col < beam_x_bits'(hex_digits)) && (row < beam_y_bits'(2));
  assign bit_sel  = 4'(py * glyph_w + px);

  always_comb
  begin
    pixel_on = 1'b0;
    if (in_glyph && in_text && !beam.blank)
      pixel_on = glyph[4'd14 - bit_sel];
  end

  // one pipeline stage, syncs delayed to stay aligned with colour
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      color     <= color_bg;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      blank_out <= 1'b0;
    end
    else
    begin
      color     <= pixel_on ? color_fg : color_bg;
      hsync_out <= beam.hsync;
      vsync_out <= beam.vsync;
      blank_out <= beam.blank;
    end
  end

endmodule

// File: verilog/collatz_display_top.sv
// collatz display top level
// step control, search engine, raster timing and hex readout
`timescale 1ns/100ps

module collatz_display_top import collatz_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    btn_step,
  input  logic                    run,
  output logic [collatz_bits-1:0] start_num,
  output logic [collatz_bits-1:0] actual,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blank,
  output logic [color_bits-1:0]   color
);

  logic step;

  video_beam_if beam ();

  step_control step_control_i
  (
    .clk      (clk),
    .rst      (rst),
    .btn_step (btn_step),
    .run      (run),
    .step     (step)
  );

  collatz_explorer collatz_explorer_i
  (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .start_num (start_num),
    .actual    (actual)
  );

  video_timing video_timing_i
  (
    .clk  (clk),
    .rst  (rst),
    .beam (beam.source)
  );

  // syncs and blank leave through the renderer, aligned with colour
  hex_text_renderer hex_text_renderer_i
  (
    .clk       (clk),
    .rst       (rst),
    .beam      (beam.sink),
    .start_num (start_num),
    .actual    (actual),
    .color     (color),
    .hsync_out (hsync),
    .vsync_out (vsync),
    .blank_out (blank)
  );

endmodule

// File: tb/collatz_explorer_props.sv
// collatz explorer assertions
// start number only grows, proof step reloads actual, registers hold without step
`timescale 1ns/100ps

module collatz_explorer_props import collatz_pkg::*;
(
  input logic                    clk,
  input logic                    rst,
  input logic                    step,
  input logic [collatz_bits-1:0] start_num,
  input logic [collatz_bits-1:0] actual
);

  start_never_decreases: assert property (
    @(posedge clk) disable iff (rst)
    1'b1 |=> (start_num >= $past(start_num))
  ) else $error("start_num decreased");

  // proven start moves on with actual reloaded
  proof_reloads_actual: assert property (
    @(posedge clk) disable iff (rst)
    (step && (actual < start_num)) |=> (actual == start_num)
  ) else $error("actual differs from new start_num after a proof step");

  hold_without_step: assert property (
    @(posedge clk) disable iff (rst)
    !step |=> ($stable(start_num) && $stable(actual))
  ) else $error("search registers changed without a step");

endmodule

bind collatz_explorer collatz_explorer_props collatz_explorer_props_i
(
  .clk       (clk),
  .rst       (rst),
  .step      (step),
  .start_num (start_num),
  .actual    (actual)
);

// File: tb/collatz_display_tb.sv
// collatz display testbench
// button and run stepping, debounce, raster timing and hex readout checks
`timescale 1ns/100ps

module collatz_display_tb import collatz_pkg::*; ();

  logic                    clk;
  logic                    rst;
  logic                    btn_step;
  logic                    run;
  logic [collatz_bits-1:0] start_num;
  logic [collatz_bits-1:0] actual;
  logic                    hsync;
  logic                    vsync;
  logic                    blank;
  logic [color_bits-1:0]   color;

  int   errors;
  int   checks;
  int   r;
  int   k;
  logic vsync_seen;

  // reference search state
  logic [collatz_bits-1:0] model_start;
  logic [collatz_bits-1:0] model_actual;

  // one row per action
  // run flag clear means button presses
  // an expected pair of zero means only the reference model applies
  bit                      row_run    [0:8] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};
  int                      row_count  [0:8] = '{1, 1, 1, 1, 1, 1, 1, 40, 3};
  logic [collatz_bits-1:0] row_start  [0:8] = '{3, 3, 3, 3, 3, 3, 4, 0, 0};
  logic [collatz_bits-1:0] row_actual [0:8] = '{10, 5, 16, 8, 4, 2, 4, 0, 0};

  // 3x5 hex font with the top left pixel in bit 14
  logic [14:0] font [0:15] = '{
    15'b111_101_101_101_111, 15'b010_110_010_010_111,
    15'b111_001_111_100_111, 15'b111_001_111_001_111,
    15'b101_101_111_001_001, 15'b111_100_111_001_111,
    15'b111_100_111_101_111, 15'b111_001_001_001_001,
    15'b111_101_111_101_111, 15'b111_101_111_001_111,
    15'b010_101_111_101_101, 15'b110_101_110_101_110,
    15'b011_100_100_100_011, 15'b110_101_101_101_110,
    15'b111_100_111_100_111, 15'b111_100_111_100_100
  };

  collatz_display_top collatz_display_top_i
  (
    .clk       (clk),
    .rst       (rst),
    .btn_step  (btn_step),
    .run       (run),
    .start_num (start_num),
    .actual    (actual),
    .hsync     (hsync),
    .vsync     (vsync),
    .blank     (blank),
    .color     (color)
  );

  always #20 clk = ~clk;

  // drive and sample slot just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string what, input logic [collatz_bits-1:0] got,
                             input logic [collatz_bits-1:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("FAIL t=%0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic check_state(input string what);
    check_value({what, " start_num"}, start_num, model_start);
    check_value({what, " actual"}, actual, model_actual);
  endtask

  // one search step of the reference model
  task automatic model_step();
    if (model_actual < model_start)
    begin
      model_start  = model_start + 1;
      model_actual = model_start;
    end
    else if (model_actual % 2 == 1)
      model_actual = model_actual * 3 + 1;
    else
      model_actual = model_actual / 2;
  endtask

  task automatic pulse_button(input int high_cycles, input int low_cycles);
    int i;
    btn_step = 1'b1;
    for (i = 0; i < high_cycles; i++)
      next_cycle();
    btn_step = 1'b0;
    for (i = 0; i < low_cycles; i++)
      next_cycle();
  endtask

  // run switch held for a number of cycles with one model step per cycle
  task automatic run_steps(input int cycles);
    int i;
    logic [collatz_bits-1:0] last_start;
    last_start = start_num;
    run = 1'b1;
    for (i = 0; i < cycles + 3; i++)
    begin
      if (i == cycles)
        run = 1'b0;
      next_cycle();
      if (i < cycles)
        model_step();
      checks++;
      if (start_num < last_start)
      begin
        errors++;
        $display("FAIL t=%0t: start_num fell from %h to %h", $time, last_start, start_num);
      end
      last_start = start_num;
    end
  endtask

  // gives up after two frames without a rise
  task automatic wait_vsync_rise(output logic found);
    int   i;
    logic prev;
    prev  = vsync;
    found = 1'b0;
    for (i = 0; i < 2 * h_total * v_total && !found; i++)
    begin
      next_cycle();
      found = vsync && !prev;
      prev  = vsync;
    end
  endtask

  function automatic logic [color_bits-1:0] expected_color(input int x, input int y);
    int                      col;
    int                      row;
    int                      px;
    int                      py;
    logic [collatz_bits-1:0] val;
    logic [3:0]              nib;
    expected_color = color_bg;
    col = x / cell_w;
    px  = x % cell_w;
    row = y / cell_h;
    py  = y % cell_h;
    // text rows lie inside the visible area
    if (row < 2 && col < hex_digits && px < glyph_w && py < glyph_h)
    begin
      val = (row == 0) ? model_start : model_actual;
      nib = val[(hex_digits - 1 - col) * 4 +: 4];
      if (font[nib][14 - (py * glyph_w + px)])
        expected_color = color_fg;
    end
  endfunction

  // first sample after the output vsync rise shows x 0 of the first sync line
  task automatic check_frame();
    int   n;
    int   x;
    int   y;
    int   hs_rises;
    int   vs_rises;
    logic hs_prev;
    logic vs_prev;
    x        = 0;
    y        = v_sync_start;
    hs_rises = 0;
    vs_rises = 0;
    hs_prev  = 1'b0;
    vs_prev  = 1'b0;
    for (n = 0; n < h_total * v_total; n++)
    begin
      if (n != 0)
        next_cycle();
      check_value($sformatf("blank x=%0d y=%0d", x, y), blank,
                  (x >= h_visible) || (y >= v_visible));
      check_value($sformatf("hsync x=%0d y=%0d", x, y), hsync,
                  (x >= h_sync_start) && (x < h_sync_end));
      check_value($sformatf("vsync x=%0d y=%0d", x, y), vsync,
                  (y >= v_sync_start) && (y < v_sync_end));
      check_value($sformatf("color x=%0d y=%0d", x, y), color, expected_color(x, y));
      if (hsync && !hs_prev)
        hs_rises++;
      if (vsync && !vs_prev)
        vs_rises++;
      hs_prev = hsync;
      vs_prev = vsync;
      x = x + 1;
      if (x == h_total)
      begin
        x = 0;
        y = (y + 1) % v_total;
      end
    end
    check_value("hsync pulses per frame", hs_rises, v_total);
    check_value("vsync pulses per frame", vs_rises, 1);
  endtask

  initial
  begin
    clk          = 1'b0;
    rst          = 1'b1;
    btn_step     = 1'b0;
    run          = 1'b0;
    errors       = 0;
    checks       = 0;
    model_start  = start_init;
    model_actual = start_init;
    next_cycle();
    next_cycle();
    rst = 1'b0;

    check_state("reset");
    check_value("blank after reset", blank, 1'b0);
    check_value("hsync after reset", hsync, 1'b0);
    check_value("vsync after reset", vsync, 1'b0);

    for (r = 0; r < $size(row_run); r++)
    begin
      if (row_run[r])
        run_steps(row_count[r]);
      else
      begin
        for (k = 0; k < row_count[r]; k++)
        begin
          pulse_button(20, 20);
          model_step();
          check_state($sformatf("press in row %0d", r));
        end
      end
      check_state($sformatf("row %0d", r));
      if (row_start[r] != 0)
      begin
        check_value($sformatf("row %0d start_num", r), start_num, row_start[r]);
        check_value($sformatf("row %0d actual", r), actual, row_actual[r]);
      end
    end

    // longest glitch that must not step
    pulse_button(15, 25);
    check_state("after glitch");

    wait_vsync_rise(vsync_seen);
    if (vsync_seen)
      check_frame();
    else
    begin
      errors++;
      $display("timeout: no vsync pulse seen within two frames");
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: sources.f
verilog/collatz_pkg.sv
verilog/video_beam_if.sv
verilog/step_control.sv
verilog/collatz_explorer.sv
verilog/video_timing.sv
verilog/hex_text_renderer.sv
verilog/collatz_display_top.sv
tb/collatz_explorer_props.sv
tb/collatz_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the collatz display testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module collatz_display_tb \
  -f sources.f \
  -Mdir obj_dir

./obj_dir/Vcollatz_display_tb | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
